/* src.f */
common/game_pkg.sv
common/board_mem_if.sv
board/board_ram.sv
board/board_arbiter.sv
design/game_engine.sv
design/apb_board_reader.sv
design/game_top.sv
dv/game_top_assert.sv
dv/tb_game_top.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_game_top -f src.f || exit 1
sim_out="$(./obj_dir/Vtb_game_top 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* dv/tb_game_top.sv */
`timescale 1ns/1ps

module tb_game_top;
    localparam logic [31:0] seed_init  = 32'h8b02;
    localparam int          random_ops = 400;
    localparam int          wait_limit = 300;   // cycles for pready or key ack
    localparam int          poll_limit = 50;    // status polls per operation
    // W A S D SPACE Z as 0..5, then the two unused codes
    localparam int opening_keys [20] = '{1, 0, 3, 3, 2, 2, 2, 4, 5, 3,
                                         4, 1, 4, 3, 5, 5, 4, 5, 6, 7};
    // both sides grow until they touch, then a mountain and an edge block
    localparam int front_keys [56] = '{3, 4, 3, 1, 4, 0, 3, 3, 4, 3, 1, 0, 4, 0,
                                       3, 3, 3, 4, 3, 1, 0, 0, 4, 0,
                                       3, 3, 3, 3, 4, 3, 1, 0, 0, 0, 4, 0, 4, 4, 3,
                                       4, 2, 0, 0, 0, 4, 3, 2, 4, 2, 1, 0, 0, 0, 3, 4, 3};
    localparam int bad_addrs [5] = '{100, 'h0c8, 'h0ff, 'h101, 'hfff};

    logic                   clock;
    logic                   reset;
    logic                   keyboard_ready;
    logic [2:0]             keyboard_data;
    logic                   key_read_fin;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    game_pkg::apb_addr_t    paddr;
    game_pkg::apb_data_t    pwdata;
    game_pkg::apb_data_t    prdata;
    logic                   pready;
    logic                   pslverr;

    logic [31:0]            seed;
    game_pkg::cell_word_t   model [100];
    game_pkg::coord_t       m_h;
    game_pkg::coord_t       m_v;
    game_pkg::cursor_mode_t m_mode;
    game_pkg::player_t      m_player;

    game_top i_game_top (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic game_pkg::cell_word_t make_cell(game_pkg::player_t owner,
                                                       game_pkg::piece_t piece,
                                                       game_pkg::troop_t troop);
        return {owner, piece, troop};   // owner 13:11, piece 10:9, troop 8:0
    endfunction

    function automatic int cell_at(game_pkg::coord_t h, game_pkg::coord_t v);
        return int'(v) * int'(game_pkg::board_width) + int'(h);
    endfunction

    function automatic game_pkg::cell_word_t opening_cell(game_pkg::coord_t h,
                                                          game_pkg::coord_t v);
        if (h == game_pkg::crown_red_h && v == game_pkg::crown_red_v) begin
            return make_cell(game_pkg::RED, game_pkg::CROWN, game_pkg::crown_red_troop);
        end
        if (h == game_pkg::crown_blue_h && v == game_pkg::crown_blue_v) begin
            return make_cell(game_pkg::BLUE, game_pkg::CROWN, game_pkg::crown_blue_troop);
        end
        if (v == game_pkg::mountain_row && h <= game_pkg::mountain_last_h) begin
            return make_cell(game_pkg::NPC, game_pkg::MOUNTAIN, '0);
        end
        if ((h == game_pkg::city_a_h && v == game_pkg::city_a_v) ||
            (h == game_pkg::city_b_h && v == game_pkg::city_b_v)) begin
            return make_cell(game_pkg::NPC, game_pkg::CITY, game_pkg::city_troop);
        end
        return make_cell(game_pkg::NPC, game_pkg::TERRITORY, '0);
    endfunction

    function automatic game_pkg::apb_data_t model_status();
        game_pkg::apb_data_t s;
        s        = '0;
        s[3:0]   = m_h;
        s[7:4]   = m_v;
        s[9:8]   = m_mode;
        s[12:10] = m_player;
        s[16]    = 1'b1;   // idle
        return s;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_cell(input string name, input game_pkg::cell_word_t got,
                              input game_pkg::cell_word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_status(input string name, input game_pkg::apb_data_t got,
                                input game_pkg::apb_data_t exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic apb_access(input logic write, input game_pkg::apb_addr_t addr,
                              input game_pkg::apb_data_t wdata,
                              output game_pkg::apb_data_t rdata, output logic err);
        int cycles;
        @(posedge clock);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clock);
        penable <= 1'b1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (!pready && cycles >= wait_limit) begin
                stop_run($sformatf("APB access to 0x%h never got pready", addr));
            end
        end while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clock);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic send_key(input logic [2:0] code);
        int cycles;
        @(posedge clock);
        keyboard_ready <= 1'b1;
        keyboard_data  <= code;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (!key_read_fin && cycles >= wait_limit) begin
                stop_run($sformatf("key code %0d was never acknowledged", code));
            end
        end while (!key_read_fin);
        @(posedge clock);
        keyboard_ready <= 1'b0;   // key held until the engine acknowledged it
    endtask

    task automatic check_idle_status();
        game_pkg::apb_data_t rd;
        logic                err;
        int                  polls;
        polls = 0;
        do begin
            apb_access(1'b0, game_pkg::status_addr, '0, rd, err);
            check_flag("pslverr on status read", err, 1'b0);
            polls++;
            if (!rd[16] && polls >= poll_limit) begin
                stop_run("engine did not return to idle");
            end
        end while (!rd[16]);
        check_status("status word", rd, model_status());
    endtask

    task automatic check_cell_at(input int idx);
        game_pkg::apb_data_t rd;
        logic                err;
        apb_access(1'b0, game_pkg::apb_addr_t'(idx), '0, rd, err);
        check_flag("pslverr on cell read", err, 1'b0);
        check_cell($sformatf("prdata of cell %0d", idx), game_pkg::cell_word_t'(rd), model[idx]);
    endtask

    task automatic check_board();
        for (int i = 0; i < 100; i++) begin
            check_cell_at(i);
        end
    endtask

    // game rules on the model, returns the cells a move touches
    task automatic model_key(input logic [2:0] code, output int src, output int dst);
        game_pkg::coord_t     th;
        game_pkg::coord_t     tv;
        logic                 on_board;
        game_pkg::cell_word_t sw;
        game_pkg::cell_word_t dw;
        game_pkg::troop_t     moved;
        th  = m_h;
        tv  = m_v;
        src = -1;
        dst = -1;
        case (code)
            3'd0: begin
                on_board = (m_v > 4'd0);
                tv = m_v - 4'd1;
            end
            3'd1: begin
                on_board = (m_h > 4'd0);
                th = m_h - 4'd1;
            end
            3'd2: begin
                on_board = (m_v < game_pkg::board_width - 4'd1);
                tv = m_v + 4'd1;
            end
            3'd3: begin
                on_board = (m_h < game_pkg::board_width - 4'd1);
                th = m_h + 4'd1;
            end
            default: on_board = 1'b0;
        endcase
        sw = model[cell_at(m_h, m_v)];
        if (code == 3'd4) begin
            if (m_mode != game_pkg::CHOOSE) begin
                m_mode = game_pkg::CHOOSE;
            end else if (sw[13:11] == m_player && sw[8:0] >= 9'd2) begin
                m_mode = game_pkg::MOVE_TOTAL;
            end
        end else if (code == 3'd5 && m_mode != game_pkg::CHOOSE) begin
            m_mode = (m_mode == game_pkg::MOVE_TOTAL) ? game_pkg::MOVE_HALF
                                                     : game_pkg::MOVE_TOTAL;
        end else if (code <= 3'd3 && m_mode == game_pkg::CHOOSE && on_board) begin
            m_h = th;
            m_v = tv;
        end else if (code <= 3'd3 && m_mode != game_pkg::CHOOSE) begin
            src = cell_at(m_h, m_v);
            if (on_board) begin
                dst = cell_at(th, tv);
                dw  = model[dst];
                // only neutral territory or city can be taken
                if (dw[13:11] == game_pkg::NPC &&
                    (dw[10:9] == game_pkg::TERRITORY || dw[10:9] == game_pkg::CITY)) begin
                    moved = (m_mode == game_pkg::MOVE_TOTAL) ? sw[8:0] - 9'd1 : sw[8:0] / 2;
                    model[dst] = make_cell(m_player, game_pkg::piece_t'(dw[10:9]), moved);
                    model[src] = make_cell(m_player, game_pkg::piece_t'(sw[10:9]),
                                           sw[8:0] - moved);
                    m_player = (m_player == game_pkg::RED) ? game_pkg::BLUE : game_pkg::RED;
                    m_h = (m_player == game_pkg::RED) ? game_pkg::crown_red_h
                                                      : game_pkg::crown_blue_h;
                    m_v = (m_player == game_pkg::RED) ? game_pkg::crown_red_v
                                                      : game_pkg::crown_blue_v;
                    m_mode = game_pkg::CHOOSE;
                end
            end
        end
    endtask

    task automatic run_key(input logic [2:0] code);
        int src;
        int dst;
        model_key(code, src, dst);
        send_key(code);
        check_idle_status();
        if (src >= 0) begin
            check_cell_at(src);
        end
        if (dst >= 0) begin
            check_cell_at(dst);
        end
    endtask

    initial begin
        logic [2:0]          code;
        game_pkg::apb_data_t rd;
        logic                err;
        reset          = 1'b1;
        keyboard_ready = 1'b0;
        keyboard_data  = 3'd0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        seed           = seed_init;
        for (int i = 0; i < 100; i++) begin
            model[i] = opening_cell(game_pkg::coord_t'(i % 10), game_pkg::coord_t'(i / 10));
        end
        m_h      = '0;
        m_v      = '0;
        m_mode   = game_pkg::CHOOSE;
        m_player = game_pkg::RED;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        check_board();   // first read stalls until the fill ends
        check_idle_status();

        // walk to the red crown, half move, blue full move, then blocked and mode keys
        foreach (opening_keys[i]) begin
            run_key(3'(opening_keys[i]));
        end

        foreach (front_keys[i]) begin
            run_key(3'(front_keys[i]));
        end

        for (int n = 0; n < random_ops; n++) begin
            seed = xorshift32(seed);
            if (seed[3:0] < 4'd9) begin
                code = {1'b0, seed[9:8]};   // W A S D
            end else if (seed[3:0] < 4'd13) begin
                code = 3'd4;
            end else if (seed[3:0] < 4'd15) begin
                code = 3'd5;
            end else begin
                code = {2'b11, seed[10]};
            end
            run_key(code);
        end

        foreach (bad_addrs[i]) begin
            seed = xorshift32(seed);
            apb_access(1'b0, game_pkg::apb_addr_t'(bad_addrs[i]), '0, rd, err);
            check_flag("pslverr on bad read", err, 1'b1);
            apb_access(1'b1, game_pkg::apb_addr_t'(bad_addrs[i]), seed, rd, err);
            check_flag("pslverr on bad write", err, 1'b1);
        end
        apb_access(1'b1, game_pkg::apb_addr_t'(seed % 100), ~seed, rd, err);
        check_flag("pslverr on cell write", err, 1'b1);
        apb_access(1'b1, game_pkg::status_addr, seed, rd, err);
        check_flag("pslverr on status write", err, 1'b1);
        check_board();
        check_idle_status();

        if (i_game_top.i_game_top_assert.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            stop_run("concurrent assertions reported failures");
        end
    end

endmodule

/* dv/game_top_assert.sv */
`timescale 1ns/1ps

module game_top_assert (
    input logic clock,
    input logic reset,
    input logic key_read_fin,
    input logic eng_gnt,
    input logic host_gnt,
    input logic mem_ready,
    input logic pready,
    input logic pslverr
);
    int fail_count = 0;   // read by the testbench at the end

    fin_pulse: assert property (@(posedge clock) disable iff (reset)
                                key_read_fin |=> !key_read_fin)
        else begin
            $error("key_read_fin high for two cycles in a row");
            fail_count++;
        end

    one_grant: assert property (@(posedge clock) disable iff (reset)
                                !(eng_gnt && host_gnt))
        else begin
            $error("engine and host granted in the same cycle");
            fail_count++;
        end

    grant_when_ready: assert property (@(posedge clock) disable iff (reset)
                                       (eng_gnt || host_gnt) |-> mem_ready)
        else begin
            $error("grant given while the board memory is not ready");
            fail_count++;
        end

    err_with_ready: assert property (@(posedge clock) disable iff (reset)
                                     pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            fail_count++;
        end

endmodule

bind game_top game_top_assert i_game_top_assert (
    .clock        (clock),
    .reset        (reset),
    .key_read_fin (key_read_fin),
    .eng_gnt      (eng_port.gnt),
    .host_gnt     (host_port.gnt),
    .mem_ready    (ram_port.gnt),
    .pready       (pready),
    .pslverr      (pslverr)
);

/* design/game_top.sv */
`timescale 1ns/1ps

module game_top (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 keyboard_ready,
    input  logic [2:0]           keyboard_data,
    output logic                 key_read_fin,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  game_pkg::apb_addr_t  paddr,
    input  game_pkg::apb_data_t  pwdata,
    output game_pkg::apb_data_t  prdata,
    output logic                 pready,
    output logic                 pslverr
);
    game_pkg::coord_t       cursor_h;
    game_pkg::coord_t       cursor_v;
    game_pkg::cursor_mode_t cursor_mode;
    game_pkg::player_t      current_player;
    logic                   idle;

    board_mem_if eng_port ();
    board_mem_if host_port ();
    board_mem_if ram_port ();

    game_engine i_game_engine (
        .clock          (clock),
        .reset          (reset),
        .keyboard_ready (keyboard_ready),
        .keyboard_data  (game_pkg::key_op_t'(keyboard_data)),   // 6 and 7 pass through
        .key_read_fin   (key_read_fin),
        .mem            (eng_port.requester),
        .cursor_h       (cursor_h),
        .cursor_v       (cursor_v),
        .cursor_mode    (cursor_mode),
        .current_player (current_player),
        .idle           (idle)
    );

    apb_board_reader i_apb_board_reader (
        .clock (clock),
        .reset (reset),
        .psel (psel),
        .penable (penable),
        .pwrite (pwrite),
        .paddr (paddr),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr (pslverr),
        .mem (host_port.requester),
        .cursor_h (cursor_h),
        .cursor_v (cursor_v),
        .cursor_mode (cursor_mode),
        .current_player (current_player),
        .idle (idle)
    );

    board_arbiter i_board_arbiter (
        .clock (clock),
        .reset (reset),
        .eng   (eng_port.arbiter),
        .host  (host_port.arbiter),
        .mem   (ram_port.requester)
    );

    board_ram i_board_ram (
        .clock (clock),
        .reset (reset),
        .mem   (ram_port.arbiter)
    );

endmodule

/* design/apb_board_reader.sv */
`timescale 1ns/1ps

module apb_board_reader (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  game_pkg::apb_addr_t     paddr,
    input  game_pkg::apb_data_t     pwdata,
    output game_pkg::apb_data_t     prdata,
    output logic                    pready,
    output logic                    pslverr,
    board_mem_if.requester          mem,
    input  game_pkg::coord_t        cursor_h,
    input  game_pkg::coord_t        cursor_v,
    input  game_pkg::cursor_mode_t  cursor_mode,
    input  game_pkg::player_t       current_player,
    input  logic                    idle
);
    logic                access;
    logic                cell_rd;
    logic                status_rd;
    logic                rd_done;       // cell word on rdata this cycle
    game_pkg::apb_data_t status_word;

    assign access    = psel && penable;
    assign cell_rd   = access && !pwrite &&
                       (paddr < game_pkg::apb_addr_t'(game_pkg::cell_count));
    assign status_rd = access && !pwrite && (paddr == game_pkg::status_addr);

    always_comb begin
        status_word        = '0;
        status_word[3:0]   = cursor_h;
        status_word[7:4]   = cursor_v;
        status_word[9:8]   = cursor_mode;
        status_word[12:10] = current_player;
        status_word[16]    = idle;
    end

    // writes are not supported, pwdata is ignored
    assign mem.req   = cell_rd && !rd_done;
    assign mem.we    = 1'b0;
    assign mem.addr  = game_pkg::cell_addr_t'(paddr);
    assign mem.wdata = '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_done <= 1'b0;
        end else begin
            rd_done <= mem.req && mem.gnt;
        end
    end

    assign pready  = access && (!cell_rd || rd_done);
    assign pslverr = access && !cell_rd && !status_rd;
    assign prdata  = cell_rd   ? game_pkg::apb_data_t'(mem.rdata)
                   : status_rd ? status_word
                   : '0;

endmodule

/* design/game_engine.sv */
`timescale 1ns/1ps

module game_engine (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    keyboard_ready,
    input  game_pkg::key_op_t       keyboard_data,
    output logic                    key_read_fin,
    board_mem_if.requester          mem,
    output game_pkg::coord_t        cursor_h,
    output game_pkg::coord_t        cursor_v,
    output game_pkg::cursor_mode_t  cursor_mode,
    output game_pkg::player_t       current_player,
    output logic                    idle
);
    game_pkg::engine_state_t state;
    game_pkg::key_op_t       op;           // pending operation, NONE when empty
    logic                    rd_valid;     // rdata holds the last granted read
    game_pkg::piece_t        src_piece;
    game_pkg::troop_t        src_troop;
    game_pkg::piece_t        dst_piece;
    game_pkg::coord_t        tgt_h;
    game_pkg::coord_t        tgt_v;
    logic                    on_board;
    game_pkg::player_t       rd_owner;
    game_pkg::piece_t        rd_piece;
    game_pkg::troop_t        rd_troop;
    game_pkg::troop_t        moved_troop;
    game_pkg::player_t       next_player;
    logic                    move_mode;

    assign rd_owner = game_pkg::player_t'(mem.rdata[game_pkg::owner_lsb +: 3]);
    assign rd_piece = game_pkg::piece_t'(mem.rdata[game_pkg::piece_lsb +: 2]);
    assign rd_troop = mem.rdata[game_pkg::troop_lsb +: 9];

    assign move_mode   = cursor_mode[1];
    assign next_player = (current_player == game_pkg::RED) ? game_pkg::BLUE : game_pkg::RED;
    assign moved_troop = (cursor_mode == game_pkg::MOVE_TOTAL) ? src_troop - 1'b1
                                                              : src_troop >> 1;
    assign idle = (state == game_pkg::IDLE) && (op == game_pkg::NONE);

    // neighbour in the key direction, used for both steps and moves
    always_comb begin
        tgt_h    = cursor_h;
        tgt_v    = cursor_v;
        on_board = 1'b0;
        case (op)
            game_pkg::W: begin
                on_board = (cursor_v != '0);
                tgt_v    = cursor_v - 1'b1;
            end
            game_pkg::A: begin
                on_board = (cursor_h != '0);
                tgt_h    = cursor_h - 1'b1;
            end
            game_pkg::S: begin
                on_board = (cursor_v != game_pkg::board_width - 1'b1);
                tgt_v    = cursor_v + 1'b1;
            end
            game_pkg::D: begin
                on_board = (cursor_h != game_pkg::board_width - 1'b1);
                tgt_h    = cursor_h + 1'b1;
            end
            default: ;
        endcase
    end

    assign mem.we  = (state == game_pkg::WRITE_DST) || (state == game_pkg::WRITE_SRC);
    assign mem.req = mem.we ||
                     (((state == game_pkg::READ_SRC) || (state == game_pkg::READ_DST)) &&
                      !rd_valid);
    assign mem.addr = ((state == game_pkg::READ_SRC) || (state == game_pkg::WRITE_SRC))
                    ? game_pkg::cell_index(cursor_h, cursor_v)
                    : game_pkg::cell_index(tgt_h, tgt_v);
    assign mem.wdata = (state == game_pkg::WRITE_DST)
                     ? game_pkg::pack_cell(current_player, dst_piece, moved_troop)
                     : game_pkg::pack_cell(current_player, src_piece, src_troop - moved_troop);

    always_ff @(posedge clock) begin
        if (reset) begin
            state          <= game_pkg::IDLE;
            op             <= game_pkg::NONE;
            key_read_fin   <= 1'b0;
            rd_valid       <= 1'b0;
            cursor_h       <= '0;
            cursor_v       <= '0;
            cursor_mode    <= game_pkg::CHOOSE;
            current_player <= game_pkg::RED;
        end else begin
            key_read_fin <= 1'b0;
            rd_valid     <= mem.req && mem.gnt && !mem.we;
            case (state)
                game_pkg::IDLE: begin
                    if (op == game_pkg::NONE) begin
                        if (keyboard_ready && !key_read_fin) begin   // one ack per key
                            key_read_fin <= 1'b1;
                            if (keyboard_data <= game_pkg::Z) begin
                                op <= keyboard_data;   // codes 6 and 7 dropped
                            end
                        end
                    end else if (op == game_pkg::SPACE && !move_mode) begin
                        state <= game_pkg::READ_SRC;   // check the source cell first
                    end else if (move_mode && on_board) begin
                        state <= game_pkg::READ_SRC;
                    end else begin
                        op <= game_pkg::NONE;
                        if (op == game_pkg::SPACE) begin
                            cursor_mode <= game_pkg::CHOOSE;
                        end else if (op == game_pkg::Z && move_mode) begin
                            cursor_mode <= (cursor_mode == game_pkg::MOVE_TOTAL)
                                         ? game_pkg::MOVE_HALF : game_pkg::MOVE_TOTAL;
                        end else if (!move_mode && on_board) begin
                            cursor_h <= tgt_h;
                            cursor_v <= tgt_v;
                        end
                    end
                end
                game_pkg::READ_SRC: begin
                    if (rd_valid) begin
                        src_piece <= rd_piece;
                        src_troop <= rd_troop;
                        if (op == game_pkg::SPACE) begin
                            if (rd_owner == current_player && rd_troop >= 9'd2) begin
                                cursor_mode <= game_pkg::MOVE_TOTAL;
                            end
                            op    <= game_pkg::NONE;
                            state <= game_pkg::IDLE;
                        end else begin
                            state <= game_pkg::READ_DST;
                        end
                    end
                end
                game_pkg::READ_DST: begin
                    if (rd_valid) begin
                        dst_piece <= rd_piece;
                        if (rd_owner == game_pkg::NPC &&
                            (rd_piece == game_pkg::TERRITORY || rd_piece == game_pkg::CITY)) begin
                            state <= game_pkg::WRITE_DST;
                        end else begin
                            op    <= game_pkg::NONE;   // blocked move
                            state <= game_pkg::IDLE;
                        end
                    end
                end
                game_pkg::WRITE_DST: begin
                    if (mem.gnt) begin
                        state <= game_pkg::WRITE_SRC;
                    end
                end
                default: begin   // WRITE_SRC, then hand the turn over
                    if (mem.gnt) begin
                        op             <= game_pkg::NONE;
                        state          <= game_pkg::IDLE;
                        current_player <= next_player;
                        cursor_mode    <= game_pkg::CHOOSE;
                        cursor_h <= (next_player == game_pkg::BLUE) ? game_pkg::crown_blue_h
                                                                     : game_pkg::crown_red_h;
                        cursor_v <= (next_player == game_pkg::BLUE) ? game_pkg::crown_blue_v
                                                                     : game_pkg::crown_red_v;
                    end
                end
            endcase
        end
    end

endmodule

/* board/board_arbiter.sv */
`timescale 1ns/1ps

module board_arbiter (
    input  logic            clock,
    input  logic            reset,
    board_mem_if.arbiter    eng,
    board_mem_if.arbiter    host,
    board_mem_if.requester  mem
);
    logic rd_owner_eng;   // pending read belongs to the engine

    // engine wins whenever it asks
    assign eng.gnt  = mem.gnt && eng.req;
    assign host.gnt = mem.gnt && host.req && !eng.req;

    assign mem.req = eng.req || host.req;

    always_comb begin
        if (eng.req) begin
            mem.we    = eng.we;
            mem.addr  = eng.addr;
            mem.wdata = eng.wdata;
        end else begin
            mem.we    = host.we;
            mem.addr  = host.addr;
            mem.wdata = host.wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            rd_owner_eng <= 1'b0;
        end else if (mem.req && mem.gnt && !mem.we) begin
            rd_owner_eng <= eng.req;
        end
    end

    // read data only reaches the port that asked for it
    assign eng.rdata  = rd_owner_eng ? mem.rdata : '0;
    assign host.rdata = rd_owner_eng ? '0 : mem.rdata;

endmodule

/* board/board_ram.sv */
`timescale 1ns/1ps

module board_ram (
    input  logic          clock,
    input  logic          reset,
    board_mem_if.arbiter  mem
);
    game_pkg::cell_word_t cells [game_pkg::cell_count];
    game_pkg::cell_addr_t fill_idx;
    game_pkg::cell_word_t fill_word;
    logic                 filling;

    assign mem.gnt = !filling;   // not ready during the opening fill

    // opening layout for the cell under the fill counter
    always_comb begin
        fill_word = game_pkg::pack_cell(game_pkg::NPC, game_pkg::TERRITORY, '0);
        if (fill_idx == game_pkg::cell_index(game_pkg::crown_red_h, game_pkg::crown_red_v)) begin
            fill_word = game_pkg::pack_cell(game_pkg::RED, game_pkg::CROWN,
                                            game_pkg::crown_red_troop);
        end else if (fill_idx == game_pkg::cell_index(game_pkg::crown_blue_h,
                                                      game_pkg::crown_blue_v)) begin
            fill_word = game_pkg::pack_cell(game_pkg::BLUE, game_pkg::CROWN,
                                            game_pkg::crown_blue_troop);
        end else if (fill_idx >= game_pkg::cell_index('0, game_pkg::mountain_row) &&
                     fill_idx <= game_pkg::cell_index(game_pkg::mountain_last_h,
                                                      game_pkg::mountain_row)) begin
            fill_word = game_pkg::pack_cell(game_pkg::NPC, game_pkg::MOUNTAIN, '0);
        end else if (fill_idx == game_pkg::cell_index(game_pkg::city_a_h, game_pkg::city_a_v) ||
                     fill_idx == game_pkg::cell_index(game_pkg::city_b_h, game_pkg::city_b_v)) begin
            fill_word = game_pkg::pack_cell(game_pkg::NPC, game_pkg::CITY,
                                            game_pkg::city_troop);
        end
    end

    // one cell per cycle, 100 cycles in total
    always_ff @(posedge clock) begin
        if (reset) begin
            filling  <= 1'b1;
            fill_idx <= '0;
        end else if (filling) begin
            fill_idx <= fill_idx + 1'b1;
            if (fill_idx == game_pkg::cell_count - 1'b1) begin
                filling <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (filling) begin
            cells[fill_idx] <= fill_word;
        end else if (mem.req && mem.we) begin
            cells[mem.addr] <= mem.wdata;
        end
        if (mem.req && mem.gnt && !mem.we) begin
            mem.rdata <= cells[mem.addr];   // one-cycle read
        end
    end

endmodule

/* common/board_mem_if.sv */
`timescale 1ns/1ps

interface board_mem_if;
    logic                 req;
    logic                 gnt;     // on the memory side this is ready
    logic                 we;
    game_pkg::cell_addr_t addr;
    game_pkg::cell_word_t wdata;
    game_pkg::cell_word_t rdata;   // valid the cycle after a granted read

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );
endinterface

/* common/game_pkg.sv */
package game_pkg;

    typedef logic [3:0]  coord_t;
    typedef logic [8:0]  troop_t;
    typedef logic [6:0]  cell_addr_t;   // v * 10 + h
    typedef logic [13:0] cell_word_t;   // owner, piece, troop
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;

    typedef enum logic [2:0] {NPC, RED, BLUE} player_t;
    typedef enum logic [1:0] {TERRITORY, MOUNTAIN, CROWN, CITY} piece_t;
    typedef enum logic [1:0] {
        CHOOSE     = 2'b00,
        MOVE_TOTAL = 2'b10,
        MOVE_HALF  = 2'b11
    } cursor_mode_t;
    typedef enum logic [2:0] {W, A, S, D, SPACE, Z, NONE} key_op_t;
    typedef enum logic [2:0] {IDLE, READ_SRC, READ_DST, WRITE_DST, WRITE_SRC} engine_state_t;

    localparam coord_t     board_width      = 4'd10;
    localparam cell_addr_t cell_count       = 7'd100;
    localparam coord_t     crown_red_h      = 4'd2;
    localparam coord_t     crown_red_v      = 4'd3;
    localparam coord_t     crown_blue_h     = 4'd8;
    localparam coord_t     crown_blue_v     = 4'd7;
    localparam troop_t     crown_red_troop  = 9'h057;
    localparam troop_t     crown_blue_troop = 9'h059;
    localparam troop_t     city_troop       = 9'h043;
    localparam coord_t     mountain_row     = 4'd5;
    localparam coord_t     mountain_last_h  = 4'd3;   // mountains span h 0..3
    localparam coord_t     city_a_h         = 4'd6;
    localparam coord_t     city_a_v         = 4'd2;
    localparam coord_t     city_b_h         = 4'd4;
    localparam coord_t     city_b_v         = 4'd8;
    localparam int         owner_lsb        = 11;
    localparam int         piece_lsb        = 9;
    localparam int         troop_lsb        = 0;
    localparam apb_addr_t  status_addr      = 12'h100;

    function automatic cell_addr_t cell_index(coord_t h, coord_t v);
        return cell_addr_t'(v) * cell_addr_t'(board_width) + cell_addr_t'(h);
    endfunction

    function automatic cell_word_t pack_cell(player_t owner, piece_t piece, troop_t troop);
        cell_word_t w;
        w = '0;
        w[owner_lsb +: $bits(player_t)] = owner;
        w[piece_lsb +: $bits(piece_t)]  = piece;
        w[troop_lsb +: $bits(troop_t)]  = troop;
        return w;
    endfunction

endpackage
